/* hw/pad_defs.svh */
// Fixed by the 8-bit button layout and the 32-bit bus; pad and bit counts do not scale past one word
`ifndef PAD_DEFS_SVH
`define PAD_DEFS_SVH

// One tick every 2**PAD_DIV_BITS cycles of clk_50mhz
`define PAD_DIV_BITS 9

// Gamepads sharing latch and clock
`define PAD_COUNT 2

// Serial bits read from each pad per frame
`define PAD_BUTTONS 8

// Idle ticks after the last bit, so a frame is 32 ticks
`define PAD_GAP_TICKS 15

// Bus window
`define PAD_BASE_ADDR 32'h0200_0200
`define PAD_WIN_BITS 2

// Read response codes
`define RESP_OKAY 2'd0
`define RESP_DECERR 2'd3

`endif

/* hw/pad_pkg.sv */
// Button bit order follows the serial order of the pad; only the bus read channels are modelled
`default_nettype none

package pad_pkg;

	// One pad, pressed = 1, bit k is the k-th bit shifted in
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;
	} pad_buttons_t;

	// Read address channel payload
	typedef struct packed {
		logic [31:0] addr;
	} axil_ar_t;

	// Read data channel payload
	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	// Frame sequencer, one step per tick
	typedef enum logic [1:0] {
		seq_latch,
		seq_sample,
		seq_clock,
		seq_gap
	} pad_seq_state_t;

endpackage

`default_nettype wire

/* hw/pad_sequencer.sv */
// Latch and clock are shared by all pads; first latch comes one tick after reset release
`default_nettype none
`timescale 1ns/1ps
`include "pad_defs.svh"

module pad_sequencer import pad_pkg::*; (
	input  logic       clk_50mhz,
	input  logic       resetn,
	output logic       pad_latch,
	output logic       pad_clk,
	output logic       sample,
	output logic [2:0] bit_idx,
	output logic       frame_done
);

	localparam int GAP_W = $clog2(`PAD_GAP_TICKS + 1);
	localparam logic [2:0] LAST_BIT = 3'(`PAD_BUTTONS - 1);
	localparam logic [GAP_W-1:0] LAST_GAP = GAP_W'(`PAD_GAP_TICKS - 1);

	logic [`PAD_DIV_BITS-1:0] div_cnt;
	logic                     tick;
	pad_seq_state_t           state;
	pad_seq_state_t           state_next;
	logic [2:0]               bit_cnt;
	logic [GAP_W-1:0]         gap_cnt;
	logic                     last_bit;
	logic                     last_gap;

	// Free-running divider
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + `PAD_DIV_BITS'(1);
		end
	end

	assign tick = &div_cnt;

	assign last_bit = (bit_cnt == LAST_BIT);
	assign last_gap = (gap_cnt == LAST_GAP);

	// Next step, taken only on a tick
	always_comb begin
		state_next = state;
		if (tick) begin
			case (state)
				seq_latch:  state_next = seq_sample;
				seq_sample: state_next = seq_clock;
				seq_clock:  state_next = last_bit ? seq_gap : seq_sample;
				seq_gap:    state_next = last_gap ? seq_latch : seq_gap;
			endcase
		end
	end

	// Pins come from flops so they never glitch
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state      <= seq_gap;
			pad_latch  <= 1'b0;
			pad_clk    <= 1'b0;
			sample     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state      <= state_next;
			pad_latch  <= (state_next == seq_latch);
			pad_clk    <= (state_next == seq_clock);
			sample     <= tick && (state_next == seq_sample);
			frame_done <= tick && (state == seq_clock) && last_bit;
		end
	end

	// Bit and gap counters
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			bit_cnt <= '0;
			// Start as if the gap just ended
			gap_cnt <= LAST_GAP;
		end else if (tick) begin
			case (state)
				seq_clock: begin
					bit_cnt <= last_bit ? 3'd0 : bit_cnt + 3'd1;
					gap_cnt <= '0;
				end
				seq_gap: begin
					gap_cnt <= gap_cnt + GAP_W'(1);
				end
				default: ;
			endcase
		end
	end

	// Counter holds during seq_sample, so it names the bit being read
	assign bit_idx = bit_cnt;

endmodule

`default_nettype wire

/* hw/pad_shifter.sv */
// Assumes pad_data settles within one tick of a latch or clock edge; data is active low
`default_nettype none
`timescale 1ns/1ps

module pad_shifter import pad_pkg::*; (
	input  logic         clk_50mhz,
	input  logic         resetn,
	input  logic         pad_data,
	input  logic         sample,
	input  logic [2:0]   bit_idx,
	input  logic         frame_done,
	output pad_buttons_t buttons
);

	logic         data_meta;
	logic         data_sync;
	pad_buttons_t work;

	// Pad line is asynchronous to clk_50mhz
	always_ff @(posedge clk_50mhz) begin
		data_meta <= pad_data;
		data_sync <= data_meta;
	end

	// Working word fills one bit per sample strobe
	always_ff @(posedge clk_50mhz) begin
		if (sample) begin
			work[bit_idx] <= ~data_sync;
		end
	end

	// Published only when the whole frame is in
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			buttons <= '0;
		end else if (frame_done) begin
			buttons <= work;
		end
	end

endmodule

`default_nettype wire

/* hw/pad_bus_port.sv */
// Read channels only, one read in flight; addresses outside the 4-byte window get DECERR
`default_nettype none
`timescale 1ns/1ps
`include "pad_defs.svh"

module pad_bus_port import pad_pkg::*; (
	input  logic                          clk_50mhz,
	input  logic                          resetn,
	input  pad_buttons_t [`PAD_COUNT-1:0] buttons,
	input  axil_ar_t                      ar,
	input  logic                          ar_valid,
	output logic                          ar_ready,
	output axil_r_t                       r,
	output logic                          r_valid,
	input  logic                          r_ready
);

	localparam logic [31:0] BASE_ADDR = `PAD_BASE_ADDR;

	logic    ar_fire;
	logic    r_fire;
	logic    addr_hit;
	axil_r_t resp_next;

	// Pad p lands in byte p, upper bytes read as zero
	function automatic logic [31:0] pack_buttons(input pad_buttons_t [`PAD_COUNT-1:0] words);
		logic [31:0] data;
		data = '0;
		for (int p = 0; p < `PAD_COUNT; p++) begin
			data[p*`PAD_BUTTONS +: `PAD_BUTTONS] = words[p];
		end
		return data;
	endfunction

	// Low address bits only pick a byte inside the window
	assign addr_hit = (ar.addr[31:`PAD_WIN_BITS] == BASE_ADDR[31:`PAD_WIN_BITS]);

	// Accept a new read only when no response waits
	assign ar_ready = ~r_valid;
	assign ar_fire  = ar_valid && ar_ready;
	assign r_fire   = r_valid && r_ready;

	always_comb begin
		if (addr_hit) begin
			resp_next.data = pack_buttons(buttons);
			resp_next.resp = `RESP_OKAY;
		end else begin
			resp_next.data = '0;
			resp_next.resp = `RESP_DECERR;
		end
	end

	// Response handshake
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			r_valid <= 1'b0;
		end else if (ar_fire) begin
			r_valid <= 1'b1;
		end else if (r_fire) begin
			r_valid <= 1'b0;
		end
	end

	// Captured once per read, so later button updates leave it alone
	always_ff @(posedge clk_50mhz) begin
		if (ar_fire) begin
			r <= resp_next;
		end
	end

endmodule

`default_nettype wire

/* hw/pad_top.sv */
// Pads share one latch and one clock pin; only the read side of the bus exists
`default_nettype none
`timescale 1ns/1ps
`include "pad_defs.svh"

module pad_top import pad_pkg::*; (
	input  logic                  clk_50mhz,
	input  logic                  resetn,
	output logic                  pad_latch,
	output logic                  pad_clk,
	input  logic [`PAD_COUNT-1:0] pad_data,
	input  axil_ar_t              ar,
	input  logic                  ar_valid,
	output logic                  ar_ready,
	output axil_r_t               r,
	output logic                  r_valid,
	input  logic                  r_ready
);

	logic                          sample;
	logic [2:0]                    bit_idx;
	logic                          frame_done;
	pad_buttons_t [`PAD_COUNT-1:0] buttons;

	pad_sequencer sequencer_i (
		.clk_50mhz  (clk_50mhz),
		.resetn     (resetn),
		.pad_latch  (pad_latch),
		.pad_clk    (pad_clk),
		.sample     (sample),
		.bit_idx    (bit_idx),
		.frame_done (frame_done)
	);

	// One shifter per pad, all on the same strobes
	generate
		for (genvar p = 0; p < `PAD_COUNT; p++) begin : g_pad
			pad_shifter shifter_i (
				.clk_50mhz  (clk_50mhz),
				.resetn     (resetn),
				.pad_data   (pad_data[p]),
				.sample     (sample),
				.bit_idx    (bit_idx),
				.frame_done (frame_done),
				.buttons    (buttons[p])
			);
		end
	endgenerate

	pad_bus_port bus_port_i (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.buttons   (buttons),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready)
	);

endmodule

`default_nettype wire

/* tb/tb_pad_top.sv */
// Run from the project root so the trace path resolves; pad models shift on pad_clk rising
`default_nettype none
`timescale 1ns/1ps
`include "pad_defs.svh"

module tb_pad_top import pad_pkg::*; ();

	localparam int FRAME_CYCLES = 16384;

	logic                          clk_50mhz;
	logic                          resetn;
	logic                          pad_latch;
	logic                          pad_clk;
	wire  [`PAD_COUNT-1:0]         pad_data;
	axil_ar_t                      ar;
	logic                          ar_valid;
	logic                          ar_ready;
	axil_r_t                       r;
	logic                          r_valid;
	logic                          r_ready;
	pad_buttons_t [`PAD_COUNT-1:0] pad_val;

	string       q_name[$];
	logic [7:0]  q_pad0[$];
	logic [7:0]  q_pad1[$];
	logic [31:0] q_addr[$];
	int          q_stall[$];
	logic [31:0] q_data[$];
	logic [1:0]  q_resp[$];

	integer seed = 32'hd864_28b6;
	int     cycle_cnt = 0;
	int     timeout_cycles = 1000;
	int     pass_cnt = 0;
	int     fail_cnt = 0;
	bit     test_ok;

	pad_top dut_i (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.pad_latch (pad_latch),
		.pad_clk   (pad_clk),
		.pad_data  (pad_data),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	// Gamepad models pull the data line low while a button is pressed
	for (genvar p = 0; p < `PAD_COUNT; p++) begin : g_pad_model
		logic [7:0] sh = 8'h00;
		always @(posedge pad_latch or posedge pad_clk) begin
			#2;
			if (pad_latch) begin
				sh = pad_val[p];
			end else begin
				sh = {1'b0, sh[7:1]};
			end
		end
		assign pad_data[p] = ~sh[0];
	end

	always @(posedge clk_50mhz) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("Run timed out after %0d cycles waiting on a read or frame", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_resp(input string name, input axil_r_t exp_r, input axil_r_t act_r);
		if (act_r !== exp_r) begin
			$display("Mismatch %s: expected data %h resp %0d, actual data %h resp %0d",
				name, exp_r.data, exp_r.resp, act_r.data, act_r.resp);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_buttons(input string name, input int pad, input pad_buttons_t exp_b,
		input pad_buttons_t act_b);
		if (act_b !== exp_b) begin
			$display("Mismatch %s: pad %0d expected %b, actual %b", name, pad, exp_b, act_b);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_count(input string name, input string what, input int exp_n,
		input int act_n);
		if (act_n != exp_n) begin
			$display("Mismatch %s: %s expected %0d, actual %0d", name, what, exp_n, act_n);
			test_ok = 1'b0;
		end
	endtask

	task automatic report_test(input string name);
		if (test_ok) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s", name);
		end
	endtask

	// Sampled at the falling edge, where DUT outputs are settled
	task automatic wait_latch_rise();
		logic prev;
		@(negedge clk_50mhz);
		prev = pad_latch;
		@(negedge clk_50mhz);
		while (prev || !pad_latch) begin
			prev = pad_latch;
			@(negedge clk_50mhz);
		end
	endtask

	task automatic run_read(input string name, input logic [31:0] addr, input int stall,
		output axil_r_t got);
		axil_r_t held;
		bit      moved;
		bit      ready_seen;
		@(posedge clk_50mhz);
		#2;
		ar.addr  = addr;
		ar_valid = 1'b1;
		@(negedge clk_50mhz);
		while (!ar_ready) @(negedge clk_50mhz);
		@(posedge clk_50mhz);
		#2;
		ar_valid = 1'b0;
		ar       = '0;
		@(negedge clk_50mhz);
		if (!r_valid) begin
			$display("%s: r_valid did not rise on the cycle after the read was accepted", name);
			test_ok = 1'b0;
		end
		held       = r;
		moved      = 1'b0;
		ready_seen = ar_ready;
		for (int k = 0; k < stall; k++) begin
			@(negedge clk_50mhz);
			moved      = moved || !r_valid || (r !== held);
			ready_seen = ready_seen || ar_ready;
		end
		if (moved) begin
			$display("%s: response changed or dropped while r_ready was low", name);
			test_ok = 1'b0;
		end
		if (ready_seen) begin
			$display("%s: ar_ready went high while a response was pending", name);
			test_ok = 1'b0;
		end
		@(posedge clk_50mhz);
		#2;
		r_ready = 1'b1;
		@(posedge clk_50mhz);
		#2;
		r_ready = 1'b0;
		@(negedge clk_50mhz);
		if (r_valid || !ar_ready) begin
			$display("%s: response was not cleared after r_ready", name);
			test_ok = 1'b0;
		end
		got = held;
	endtask

	task automatic measure_frame();
		int   clk_rises;
		int   cycles;
		logic prev_clk;
		logic prev_latch;
		bit   done;
		test_ok = 1'b1;
		wait_latch_rise();
		clk_rises  = 0;
		cycles     = 0;
		prev_clk   = pad_clk;
		prev_latch = 1'b1;
		done       = 1'b0;
		while (!done) begin
			@(negedge clk_50mhz);
			cycles++;
			if (pad_clk && !prev_clk) clk_rises++;
			done       = pad_latch && !prev_latch;
			prev_clk   = pad_clk;
			prev_latch = pad_latch;
		end
		check_count("frame_timing", "pad_clk rises per frame", 8, clk_rises);
		check_count("frame_timing", "cycles between latch rises", FRAME_CYCLES, cycles);
		report_test("frame_timing");
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		string       nm;
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] va;
		logic [31:0] vd;
		logic [31:0] vr;
		int          vs;
		int          stall;
		axil_r_t     exp_r;
		axil_r_t     got;
		resetn   = 1'b0;
		ar       = '0;
		ar_valid = 1'b0;
		r_ready  = 1'b0;
		pad_val  = '0;
		fd = $fopen("tb/pad_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/pad_trace.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h %d %h %h", nm, v0, v1, va, vs, vd, vr);
					if (n == 7) begin
						q_name.push_back(nm);
						q_pad0.push_back(v0[7:0]);
						q_pad1.push_back(v1[7:0]);
						q_addr.push_back(va);
						q_stall.push_back(vs);
						q_data.push_back(vd);
						q_resp.push_back(vr[1:0]);
					end
				end
			end
			$fclose(fd);
			// Worst case per test is a wait of two frames plus the read
			timeout_cycles = (q_name.size() + 1) * 3 * FRAME_CYCLES + 1000;
			repeat (16) @(posedge clk_50mhz);
			#2;
			resetn = 1'b1;
			for (int i = 0; i < q_name.size(); i++) begin
				test_ok = 1'b1;
				if (q_pad0[i] != pad_val[0] || q_pad1[i] != pad_val[1]) begin
					pad_val[0] = q_pad0[i];
					pad_val[1] = q_pad1[i];
					wait_latch_rise();
					wait_latch_rise();
				end
				stall = q_stall[i];
				if (stall < 0) stall = ($random(seed) & 15) + 1;
				exp_r.data = q_data[i];
				exp_r.resp = q_resp[i];
				run_read(q_name[i], q_addr[i], stall, got);
				check_resp(q_name[i], exp_r, got);
				if (exp_r.resp == `RESP_OKAY) begin
					check_buttons(q_name[i], 0, pad_val[0], got.data[7:0]);
					check_buttons(q_name[i], 1, pad_val[1], got.data[15:8]);
				end
				report_test(q_name[i]);
			end
			measure_frame();
			$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0 && q_name.size() > 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/pad_trace.txt */
# name pad0 pad1 addr stall exp_data exp_resp
# pads, addr, data and resp in hex; stall in decimal cycles of r_ready low, -1 draws one at random
reset_zero      00 00 02000200 0  00000000 0
a_pad0          01 00 02000200 0  00000001 0
b_pad0          02 00 02000200 0  00000002 0
select_pad1     00 04 02000200 0  00000400 0
start_pad1      00 08 02000200 0  00000800 0
up_both         10 10 02000200 0  00001010 0
down_left       20 40 02000200 0  00004020 0
right_pad0      80 00 02000200 0  00000080 0
all_pressed     ff ff 02000200 0  0000ffff 0
split_values    a5 3c 02000200 0  00003ca5 0
win_byte1       a5 3c 02000201 0  00003ca5 0
win_byte3       a5 3c 02000203 0  00003ca5 0
next_word       a5 3c 02000204 0  00000000 3
high_addr       a5 3c 80000000 0  00000000 3
below_base      a5 3c 020001fc 0  00000000 3
zero_addr       a5 3c 00000000 0  00000000 3
stall_fixed     a5 3c 02000200 5  00003ca5 0
stall_random    a5 3c 02000200 -1 00003ca5 0
stall_rand_err  a5 3c 02000204 -1 00000000 3
stall_new_pads  5a c3 02000200 -1 0000c35a 0
stall_long      0f f0 02000200 20 0000f00f 0
clear_all       00 00 02000200 -1 00000000 0

/* vlog.f */
+incdir+hw
hw/pad_pkg.sv
hw/pad_sequencer.sv
hw/pad_shifter.sv
hw/pad_bus_port.sv
hw/pad_top.sv
tb/tb_pad_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pad_top -f vlog.f -o tb_pad_top &&
{
	out=$(./obj_dir/tb_pad_top)
	printf '%s\n' "$out"
	printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
} || {
	echo "simulation failed"
	exit 1
}
